// File: logic/demod_pkg.sv
`default_nettype none

package demod_pkg;

  // Sample and accumulator widths
  localparam int SAMPLE_W = 16;
  localparam int SUM_W    = 32;

  // Symbol timing
  localparam int SAMPLES_PER_BIT = 25;
  localparam int SYNC_BITS       = 20;
  localparam int CODE_BITS       = 10;

  // Window sums held for the older correlator taps
  localparam int CORR_DEPTH = SAMPLES_PER_BIT * (SYNC_BITS - 1);

  localparam int SAMPLE_CNT_W = $clog2(SAMPLES_PER_BIT);
  localparam int BIT_CNT_W    = $clog2(CODE_BITS + 1);
  localparam int FILL_CNT_W   = $clog2(CORR_DEPTH + 1);

  // Oldest bit in bit 19, 1 is a positive bit
  localparam logic [SYNC_BITS-1:0] SYNC_PATTERN = 20'b1100_0001_1000_1111_1001;

  typedef logic signed [SAMPLE_W-1:0] sample_t;
  typedef logic signed [SUM_W-1:0]    sum_t;
  typedef logic [CODE_BITS-1:0]       code_t;

  typedef logic [SAMPLE_CNT_W-1:0] sample_cnt_t;
  typedef logic [BIT_CNT_W-1:0]    bit_cnt_t;
  typedef logic [FILL_CNT_W-1:0]   fill_cnt_t;

  // Full scale peak is 20 taps of 25 x 1000
  localparam sum_t SYNC_THRESHOLD = sum_t'(450000);

  // Both disparity forms of the frame end symbol
  localparam code_t      END_CODE_P = 10'h143;
  localparam code_t      END_CODE_N = 10'h2BC;
  localparam logic [7:0] END_BYTE   = 8'hBC;

  typedef struct packed {
    logic [7:0] data;
    logic       first;  // First byte after sync
    logic       last;   // End code seen
  } byte_rec_t;

  typedef enum logic [1:0] {
    HUNT,
    DATA,
    DONE
  } frame_state_e;

endpackage

`default_nettype wire

// File: logic/window_sum.sv
`timescale 1ns/100ps
`default_nettype none

module window_sum (
  input  wire logic               clk,
  input  wire logic               reset,
  input  wire logic               sample_valid,
  input  demod_pkg::sample_t      sample,
  output logic                    win_valid,
  output demod_pkg::sum_t         win_sum
);

  // Last 25 samples, newest in slot 0
  demod_pkg::sample_t taps [demod_pkg::SAMPLES_PER_BIT];

  always_ff @(posedge clk) begin
    if (reset) begin
      win_valid <= 1'b0;
      win_sum   <= '0;
      for (int i = 0; i < demod_pkg::SAMPLES_PER_BIT; i++) begin
        taps[i] <= '0;
      end
    end else begin
      win_valid <= sample_valid;
      if (sample_valid) begin
        // Add the new sample, drop the one leaving the window
        win_sum <= win_sum + demod_pkg::sum_t'(sample)
                   - demod_pkg::sum_t'(taps[demod_pkg::SAMPLES_PER_BIT-1]);
        taps[0] <= sample;
        for (int i = 1; i < demod_pkg::SAMPLES_PER_BIT; i++) begin
          taps[i] <= taps[i-1];
        end
      end
    end
  end

  a_valid_follows_sample: assert property (@(posedge clk) disable iff (reset)
    win_valid |-> $past(sample_valid));

endmodule

`default_nettype wire

// File: logic/sync_correlator.sv
`timescale 1ns/100ps
`default_nettype none

module sync_correlator (
  input  wire logic           clk,
  input  wire logic           reset,
  input  wire logic           win_valid,
  input  demod_pkg::sum_t     win_sum,
  output logic                sync_hit,
  output logic                sync_neg
);

  demod_pkg::sum_t      hist [demod_pkg::CORR_DEPTH];  // Older window sums
  demod_pkg::fill_cnt_t fill_cnt;
  demod_pkg::sum_t      corr;
  logic                 primed;

  // No hits until every tap holds a real window sum
  assign primed = (fill_cnt == demod_pkg::fill_cnt_t'(demod_pkg::CORR_DEPTH));

  // Tap k sits 25*k sums back and pairs with pattern bit k
  always_comb begin
    corr = demod_pkg::SYNC_PATTERN[0] ? win_sum : -win_sum;
    for (int k = 1; k < demod_pkg::SYNC_BITS; k++) begin
      if (demod_pkg::SYNC_PATTERN[k])
        corr = corr + hist[k * demod_pkg::SAMPLES_PER_BIT - 1];
      else
        corr = corr - hist[k * demod_pkg::SAMPLES_PER_BIT - 1];
    end
  end

  always_ff @(posedge clk) begin
    if (win_valid) begin
      hist[0] <= win_sum;
      for (int i = 1; i < demod_pkg::CORR_DEPTH; i++) begin
        hist[i] <= hist[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      fill_cnt <= '0;
      sync_hit <= 1'b0;
      sync_neg <= 1'b0;
    end else begin
      if (win_valid && !primed)
        fill_cnt <= fill_cnt + demod_pkg::fill_cnt_t'(1);
      // Either sign counts, negative means inverted carrier phase
      sync_hit <= win_valid && primed &&
                  (corr >= demod_pkg::SYNC_THRESHOLD || corr <= -demod_pkg::SYNC_THRESHOLD);
      sync_neg <= win_valid && primed && (corr <= -demod_pkg::SYNC_THRESHOLD);
    end
  end

  a_neg_needs_hit: assert property (@(posedge clk) disable iff (reset)
    sync_neg |-> sync_hit);

endmodule

`default_nettype wire

// File: logic/frame_tracker.sv
`timescale 1ns/100ps
`default_nettype none

module frame_tracker (
  input  wire logic             clk,
  input  wire logic             reset,
  input  wire logic             win_valid,
  input  demod_pkg::sum_t       win_sum,
  input  wire logic             sync_hit,
  input  wire logic             sync_neg,
  output demod_pkg::code_t      code,
  input  wire logic [7:0]       dec_byte,
  input  wire logic             dec_end,
  output logic                  rec_valid,
  output demod_pkg::byte_rec_t  rec
);

  demod_pkg::frame_state_e state;
  demod_pkg::sample_cnt_t  sample_cnt;  // Window sums within the current bit
  demod_pkg::bit_cnt_t     bit_cnt;     // Bits within the current symbol
  logic                    invert;      // Sync found with negative peak
  logic                    first_sym;
  logic                    bit_slice;
  logic                    bit_val;
  logic                    sym_done;

  // The 25th sum after the last slice covers exactly one bit
  assign bit_slice = (state == demod_pkg::DATA) && win_valid &&
                     (sample_cnt == demod_pkg::sample_cnt_t'(demod_pkg::SAMPLES_PER_BIT - 1));
  assign bit_val   = ~win_sum[demod_pkg::SUM_W-1] ^ invert;
  assign sym_done  = (state == demod_pkg::DATA) &&
                     (bit_cnt == demod_pkg::bit_cnt_t'(demod_pkg::CODE_BITS));

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= demod_pkg::HUNT;
      sample_cnt <= '0;
      bit_cnt    <= '0;
      invert     <= 1'b0;
      first_sym  <= 1'b0;
      rec_valid  <= 1'b0;
    end else begin
      rec_valid <= 1'b0;
      case (state)
        demod_pkg::HUNT: begin
          if (sync_hit) begin
            state      <= demod_pkg::DATA;
            invert     <= sync_neg;
            first_sym  <= 1'b1;
            bit_cnt    <= '0;
            // A sum arriving with the hit already belongs to bit 0
            sample_cnt <= win_valid ? demod_pkg::sample_cnt_t'(1) : '0;
          end
        end
        demod_pkg::DATA: begin
          if (win_valid)
            sample_cnt <= bit_slice ? '0 : sample_cnt + demod_pkg::sample_cnt_t'(1);
          if (bit_slice) begin
            bit_cnt <= bit_cnt + demod_pkg::bit_cnt_t'(1);
          end else if (sym_done) begin
            bit_cnt   <= '0;
            rec_valid <= 1'b1;
            first_sym <= 1'b0;
            if (dec_end)
              state <= demod_pkg::DONE;
          end
        end
        demod_pkg::DONE: state <= demod_pkg::HUNT;
        default:         state <= demod_pkg::HUNT;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (bit_slice)
      code <= {bit_val, code[demod_pkg::CODE_BITS-1:1]};  // First bit ends in bit 0
    if (sym_done) begin
      rec.data  <= dec_byte;
      rec.first <= first_sym;
      rec.last  <= dec_end;
    end
  end

  a_bit_cnt_range: assert property (@(posedge clk) disable iff (reset)
    bit_cnt <= demod_pkg::bit_cnt_t'(demod_pkg::CODE_BITS));

endmodule

`default_nettype wire

// File: logic/symbol_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module symbol_decoder (
  input  demod_pkg::code_t  code,
  output logic [7:0]        dec_byte,
  output logic              dec_end
);

  logic [4:0] dec_lo;
  logic [2:0] dec_hi;

  // 5b/6b, symbol bit a in code bit 0
  always_comb begin
    case (code[5:0])
      6'b111001, 6'b000110: dec_lo = 5'd0;
      6'b101110, 6'b010001: dec_lo = 5'd1;
      6'b101101, 6'b010010: dec_lo = 5'd2;
      6'b100011:            dec_lo = 5'd3;
      6'b101011, 6'b010100: dec_lo = 5'd4;
      6'b100101:            dec_lo = 5'd5;
      6'b100110:            dec_lo = 5'd6;
      6'b000111, 6'b111000: dec_lo = 5'd7;
      6'b100111, 6'b011000: dec_lo = 5'd8;
      6'b101001:            dec_lo = 5'd9;
      6'b101010:            dec_lo = 5'd10;
      6'b001011:            dec_lo = 5'd11;
      6'b101100:            dec_lo = 5'd12;
      6'b001101:            dec_lo = 5'd13;
      6'b001110:            dec_lo = 5'd14;
      6'b111010, 6'b000101: dec_lo = 5'd15;
      6'b110110, 6'b001001: dec_lo = 5'd16;
      6'b110001:            dec_lo = 5'd17;
      6'b110010:            dec_lo = 5'd18;
      6'b010011:            dec_lo = 5'd19;
      6'b110100:            dec_lo = 5'd20;
      6'b010101:            dec_lo = 5'd21;
      6'b010110:            dec_lo = 5'd22;
      6'b010111, 6'b101000: dec_lo = 5'd23;
      6'b110011, 6'b001100: dec_lo = 5'd24;
      6'b011001:            dec_lo = 5'd25;
      6'b011010:            dec_lo = 5'd26;
      6'b011011, 6'b100100: dec_lo = 5'd27;
      6'b011100:            dec_lo = 5'd28;
      6'b011101, 6'b100010: dec_lo = 5'd29;
      6'b011110, 6'b100001: dec_lo = 5'd30;
      6'b110101, 6'b001010: dec_lo = 5'd31;
      default:              dec_lo = 5'd0;  // Not a data symbol
    endcase
  end

  // 3b/4b, both running disparities
  always_comb begin
    case (code[9:6])
      4'b1101, 4'b0010:                   dec_hi = 3'd0;
      4'b1001:                            dec_hi = 3'd1;
      4'b1010:                            dec_hi = 3'd2;
      4'b0011, 4'b1100:                   dec_hi = 3'd3;
      4'b1011, 4'b0100:                   dec_hi = 3'd4;
      4'b0101:                            dec_hi = 3'd5;
      4'b0110:                            dec_hi = 3'd6;
      4'b0111, 4'b1000, 4'b1110, 4'b0001: dec_hi = 3'd7;  // Primary and alternate forms
      default:                            dec_hi = 3'd0;
    endcase
  end

  assign dec_end  = (code == demod_pkg::END_CODE_P) || (code == demod_pkg::END_CODE_N);
  assign dec_byte = dec_end ? demod_pkg::END_BYTE : {dec_hi, dec_lo};

endmodule

`default_nettype wire

// File: logic/byte_output.sv
`timescale 1ns/100ps
`default_nettype none

module byte_output (
  input  wire logic             clk,
  input  wire logic             reset,
  input  wire logic             rec_valid,
  input  demod_pkg::byte_rec_t  rec,
  input  wire logic             stop,
  output logic                  push_byte,
  output logic [7:0]            byte_data,
  output logic                  byte_sync,
  output logic                  byte_last
);

  always_ff @(posedge clk) begin
    if (reset) begin
      push_byte <= 1'b0;
      byte_sync <= 1'b0;
      byte_last <= 1'b0;
    end else if (rec_valid) begin
      push_byte <= 1'b1;
      byte_sync <= rec.first;
      byte_last <= rec.last;
    end else if (push_byte && !stop) begin
      // Taken this cycle, flags drop with push
      push_byte <= 1'b0;
      byte_sync <= 1'b0;
      byte_last <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rec_valid)
      byte_data <= rec.data;  // Held while stop is high
  end

  // A new record must not land on a byte still held by stop
  a_no_overrun: assert property (@(posedge clk) disable iff (reset)
    rec_valid |-> !(push_byte && stop));

endmodule

`default_nettype wire

// File: logic/baseband_demod.sv
`timescale 1ns/100ps
`default_nettype none

module baseband_demod (
  input  wire logic          clk,
  input  wire logic          reset,
  input  wire logic          sample_valid,
  input  demod_pkg::sample_t sample,
  input  wire logic          stop,
  output logic               push_byte,
  output logic [7:0]         byte_data,
  output logic               byte_sync,
  output logic               byte_last
);

  logic                 win_valid;
  demod_pkg::sum_t      win_sum;
  logic                 sync_hit;
  logic                 sync_neg;
  demod_pkg::code_t     code;
  logic [7:0]           dec_byte;
  logic                 dec_end;
  logic                 rec_valid;
  demod_pkg::byte_rec_t rec;

  window_sum window_sum_i (.clk, .reset, .sample_valid, .sample, .win_valid, .win_sum);

  sync_correlator sync_correlator_i (.clk, .reset, .win_valid, .win_sum, .sync_hit, .sync_neg);

  frame_tracker frame_tracker_i (
    .clk, .reset, .win_valid, .win_sum, .sync_hit, .sync_neg,
    .code, .dec_byte, .dec_end, .rec_valid, .rec
  );

  symbol_decoder symbol_decoder_i (.code, .dec_byte, .dec_end);

  byte_output byte_output_i (
    .clk, .reset, .rec_valid, .rec, .stop,
    .push_byte, .byte_data, .byte_sync, .byte_last
  );

endmodule

`default_nettype wire

// File: sim/tb_code_table.svh
`ifndef TB_CODE_TABLE_SVH
`define TB_CODE_TABLE_SVH

// Columns: code as sent (first bit in bit 0), expected byte, expected last flag
typedef struct packed {
  logic [9:0] code;
  logic [7:0] data;
  logic       last;
} code_row_t;

typedef struct packed {
  logic invert;   // All sample signs flipped
  logic gaps;     // Random idle cycles between samples
  logic stalls;   // Random stop on every byte
  logic alt_end;  // End code of the other disparity
} frame_cfg_t;

localparam int         NUM_ROWS     = 11;
localparam int         NUM_FRAMES   = 5;
localparam int         TOTAL_BYTES  = NUM_ROWS * NUM_FRAMES;
localparam logic [9:0] ALT_END_CODE = 10'h2BC;

localparam code_row_t CODES [NUM_ROWS] = '{
  '{10'h379, 8'h00, 1'b0},  // D.0.0 RD-
  '{10'h086, 8'h00, 1'b0},  // D.0.0 RD+
  '{10'h155, 8'hB5, 1'b0},  // Neutral D.21.5
  '{10'h0D7, 8'h77, 1'b0},  // D.23.3 RD-
  '{10'h328, 8'h77, 1'b0},  // D.23.3 RD+
  '{10'h1EB, 8'hE4, 1'b0},  // D.4.7 RD-
  '{10'h214, 8'hE4, 1'b0},  // D.4.7 RD+
  '{10'h2B6, 8'h50, 1'b0},  // D.16.2 RD-
  '{10'h26A, 8'h2A, 1'b0},
  '{10'h10A, 8'h9F, 1'b0},  // D.31.4 RD+
  '{10'h143, 8'hBC, 1'b1}   // End of frame
};

// Frames in the order sent
localparam frame_cfg_t FRAMES [NUM_FRAMES] = '{
  '{1'b0, 1'b0, 1'b0, 1'b0},
  '{1'b1, 1'b0, 1'b0, 1'b1},  // 180 degree phase
  '{1'b0, 1'b0, 1'b1, 1'b0},
  '{1'b0, 1'b1, 1'b0, 1'b0},
  '{1'b1, 1'b1, 1'b1, 1'b1}
};

function automatic string frame_name(input int f);
  case (f)
    0:       return "normal";
    1:       return "inverted";
    2:       return "stop";
    3:       return "gaps";
    default: return "mixed";
  endcase
endfunction

`endif

// File: sim/tb_baseband_demod.sv
`timescale 1ns/100ps
`default_nettype none

module tb_baseband_demod;

  `include "tb_code_table.svh"

  localparam int AMPLITUDE     = 1000;
  localparam int LEAD_ZEROS    = 600;
  localparam int FLUSH_ZEROS   = 550;  // Longer than the 20-bit correlator span
  localparam int MAX_GAP       = 3;
  localparam int MAX_STOP      = 150;
  localparam int TAIL_CYCLES   = 300;
  localparam int FRAME_SAMPLES = (20 + NUM_ROWS * 10) * 25;
  localparam logic [19:0] SYNC_WORD = 20'b1100_0001_1000_1111_1001;  // Oldest bit in bit 19

  logic               clk;
  logic               reset;
  logic               sample_valid;
  demod_pkg::sample_t sample;
  logic               stop;
  logic               push_byte;
  logic [7:0]         byte_data;
  logic               byte_sync;
  logic               byte_last;

  int         rx_count;  // Bytes taken so far
  int         hold_cnt;  // Stop cycles left on the current byte
  bit         holding;
  bit         released;
  bit         zeros_only;
  logic [9:0] held_out;
  longint     cycle_cnt;
  longint     cycle_limit;

  baseband_demod baseband_demod_i (
    .clk, .reset, .sample_valid, .sample, .stop,
    .push_byte, .byte_data, .byte_sync, .byte_last
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Simulation finished: FAIL");
    $fatal(1, "Run stopped at the first error");
  endtask

  function automatic string test_name();
    return $sformatf("%s frame row %0d", frame_name(rx_count / NUM_ROWS), rx_count % NUM_ROWS);
  endfunction

  // Worst case of gaps and stops, plus half again
  function automatic longint cycle_budget();
    longint total;
    longint frame_cycles;
    total = 10 + LEAD_ZEROS + TAIL_CYCLES;
    for (int f = 0; f < NUM_FRAMES; f++) begin
      frame_cycles = FRAME_SAMPLES + FLUSH_ZEROS + 10;
      if (FRAMES[f].gaps)
        frame_cycles = frame_cycles * (MAX_GAP + 1);
      if (FRAMES[f].stalls)
        frame_cycles = frame_cycles + NUM_ROWS * MAX_STOP;
      total = total + frame_cycles;
    end
    return total * 3 / 2;
  endfunction

  task automatic send_sample(input int value, input bit with_gaps);
    int gap;
    gap = with_gaps ? $urandom_range(MAX_GAP, 0) : 0;
    repeat (gap) begin
      @(negedge clk);
      sample_valid = 1'b0;
    end
    @(negedge clk);
    sample_valid = 1'b1;
    sample       = demod_pkg::sample_t'(value);
  endtask

  task automatic send_bit(input logic b, input logic inv, input bit with_gaps);
    repeat (25) send_sample((b ^ inv) ? AMPLITUDE : -AMPLITUDE, with_gaps);
  endtask

  task automatic send_frame(input int f);
    frame_cfg_t cfg;
    logic [9:0] code;
    cfg = FRAMES[f];
    for (int i = 19; i >= 0; i--)
      send_bit(SYNC_WORD[i], cfg.invert, cfg.gaps);
    for (int r = 0; r < NUM_ROWS; r++) begin
      code = (cfg.alt_end && CODES[r].last) ? ALT_END_CODE : CODES[r].code;
      for (int b = 0; b < 10; b++)
        send_bit(code[b], cfg.invert, cfg.gaps);  // Lowest bit first
    end
    while (rx_count < (f + 1) * NUM_ROWS)
      send_sample(0, cfg.gaps);
    repeat (FLUSH_ZEROS) send_sample(0, cfg.gaps);
  endtask

  task automatic check_new_byte();
    code_row_t exp_row;
    int        row;
    assert (!zeros_only) else report_failure("push_byte rose while only zero samples arrived");
    assert (rx_count < TOTAL_BYTES) else report_failure("More bytes came out than were sent");
    row     = rx_count % NUM_ROWS;
    exp_row = CODES[row];
    assert (byte_data == exp_row.data) else report_failure($sformatf(
      "Mismatch %s byte_data: expected 8'h%02h, actual 8'h%02h",
      test_name(), exp_row.data, byte_data));
    assert (byte_sync == (row == 0)) else report_failure($sformatf(
      "Mismatch %s byte_sync: expected %0d, actual %0d", test_name(), row == 0, byte_sync));
    assert (byte_last == exp_row.last) else report_failure($sformatf(
      "Mismatch %s byte_last: expected %0d, actual %0d", test_name(), exp_row.last, byte_last));
  endtask

  initial begin
    void'($urandom(32'h60bc960a));
    reset        = 1'b1;
    sample_valid = 1'b0;
    sample       = '0;
    stop         = 1'b0;
    zeros_only   = 1'b1;
    rx_count     = 0;
    cycle_cnt    = 0;
    cycle_limit  = cycle_budget();
    repeat (10) @(negedge clk);
    reset = 1'b0;
    repeat (LEAD_ZEROS) send_sample(0, 1'b0);
    zeros_only = 1'b0;
    for (int f = 0; f < NUM_FRAMES; f++)
      send_frame(f);
    @(negedge clk);
    sample_valid = 1'b0;
    repeat (TAIL_CYCLES) @(negedge clk);  // Room for a stray byte to show up
    if (rx_count == TOTAL_BYTES && !holding) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      report_failure($sformatf("Run ended with %0d of %0d bytes taken", rx_count, TOTAL_BYTES));
    end
  end

  // Output monitor, also drives stop
  always @(negedge clk) begin
    if (!reset) begin
      if (released) begin
        assert (!push_byte) else report_failure("push_byte stayed high after the byte was taken");
        released = 1'b0;
        holding  = 1'b0;
        rx_count++;
      end else if (push_byte) begin
        if (!holding) begin
          check_new_byte();
          held_out = {byte_data, byte_sync, byte_last};
          holding  = 1'b1;
          hold_cnt = FRAMES[rx_count / NUM_ROWS].stalls ? $urandom_range(MAX_STOP, 1) : 0;
        end else begin
          assert ({byte_data, byte_sync, byte_last} == held_out) else report_failure($sformatf(
            "Mismatch %s held output: expected 10'h%03h, actual 10'h%03h",
            test_name(), held_out, {byte_data, byte_sync, byte_last}));
        end
        if (hold_cnt > 0) begin
          stop = 1'b1;
          hold_cnt--;
        end else begin
          stop     = 1'b0;  // Byte taken on the next rising edge
          released = 1'b1;
        end
      end else begin
        assert (!holding) else report_failure("push_byte dropped while stop was still high");
        assert (!byte_sync && !byte_last) else
          report_failure("byte_sync or byte_last high while push_byte is low");
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit)
      report_failure($sformatf("Timeout after %0d cycles with %0d bytes taken",
                               cycle_cnt, rx_count));
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+sim
logic/demod_pkg.sv
logic/window_sum.sv
logic/sync_correlator.sv
logic/frame_tracker.sv
logic/symbol_decoder.sv
logic/byte_output.sv
logic/baseband_demod.sv
sim/tb_baseband_demod.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_baseband_demod -Mdir obj_dir

sim_output=$(./obj_dir/Vtb_baseband_demod 2>&1 || true)
echo "$sim_output"

if grep -qx "Simulation finished: PASS" <<< "$sim_output"; then
  exit 0
fi
exit 1
